//--- common/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define DATA_W 32
`define REG_COUNT 32
`define RESET_PC 32'hbfc00000

`endif

//--- common/isaPkg.sv
package isaPkg;

	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0] op;
			logic [25:0] target;
		} j;
	} instrWord;

	localparam logic [5:0] opSpecial = 6'h00, opJ = 6'h02, opJal = 6'h03;
	localparam logic [5:0] opBeq = 6'h04, opBne = 6'h05;
	localparam logic [5:0] opAddiu = 6'h09, opSlti = 6'h0a, opAndi = 6'h0c;
	localparam logic [5:0] opOri = 6'h0d, opXori = 6'h0e, opLui = 6'h0f;
	localparam logic [5:0] opLb = 6'h20, opLw = 6'h23, opLbu = 6'h24;
	localparam logic [5:0] opSb = 6'h28, opSw = 6'h2b;

	localparam logic [5:0] fnSll = 6'h00, fnSrl = 6'h02, fnSra = 6'h03, fnJr = 6'h08;
	localparam logic [5:0] fnAddu = 6'h21, fnSubu = 6'h23, fnAnd = 6'h24, fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26, fnNor = 6'h27, fnSlt = 6'h2a, fnSltu = 6'h2b;

endpackage

//--- common/pipePkg.sv
package pipePkg;

	localparam logic [3:0] aluAdd = 4'd0, aluSub = 4'd1, aluAnd = 4'd2, aluOr = 4'd3;
	localparam logic [3:0] aluXor = 4'd4, aluNor = 4'd5, aluSlt = 4'd6, aluSltu = 4'd7;
	localparam logic [3:0] aluSll = 4'd8, aluSrl = 4'd9, aluSra = 4'd10, aluLui = 4'd11;

	// Writeback source.
	localparam logic [1:0] wbAlu = 2'd0;
	localparam logic [1:0] wbMem = 2'd1;
	localparam logic [1:0] wbLink = 2'd2;

	// Access size.
	localparam logic [1:0] memWord = 2'd0;
	localparam logic [1:0] memByte = 2'd1;
	localparam logic [1:0] memByteU = 2'd2;

	// Operand source.
	localparam logic [1:0] fwdReg = 2'd0;
	localparam logic [1:0] fwdMem = 2'd1;
	localparam logic [1:0] fwdWb = 2'd2;

endpackage

//--- decode/regFile.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module regFile #(localparam int addrW = $clog2(`REG_COUNT)) (
	input logic clk, rst, we,
	input logic [addrW-1:0] raddrA, raddrB, waddr,
	input logic [`DATA_W-1:0] wdata,
	output logic [`DATA_W-1:0] rdataA, rdataB
);
	logic [`DATA_W-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (rst)
			regs[0] <= '0; // Never written after this.
		else if (we && waddr != '0)
			regs[waddr] <= wdata;
	end

	// WB value is visible to decode in the same cycle.
	assign rdataA = (we && waddr != '0 && waddr == raddrA) ? wdata : regs[raddrA];
	assign rdataB = (we && waddr != '0 && waddr == raddrB) ? wdata : regs[raddrB];

	aZeroA: assert property (@(posedge clk) disable iff (rst) raddrA == '0 |-> rdataA == '0);
	aZeroB: assert property (@(posedge clk) disable iff (rst) raddrB == '0 |-> rdataB == '0);

endmodule

//--- decode/decodeStage.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decodeStage (
	input logic clk, rst, stall,
	input logic [`DATA_W-1:0] idPc,
	input isaPkg::instrWord idInstr,
	input logic [1:0] fwdA, fwdB,
	input logic [`DATA_W-1:0] memResult, wbData,
	input logic wbWe,
	input logic [4:0] wbDest,
	output logic branchTaken, idIsBranch,
	output logic [`DATA_W-1:0] branchTarget,
	output logic [4:0] srcRs, srcRt,
	output logic [`DATA_W-1:0] exPc, exA, exB, exImm,
	output logic [3:0] exAluOp,
	output logic exUseImm, exRegWe, exMemRd, exMemWr,
	output logic [4:0] exDest, exRs, exRt,
	output logic [1:0] exMemSize, exWbSel
);
	logic [`DATA_W-1:0] rdataA, rdataB, rsVal, rtVal, immExt;
	logic [5:0] op;
	logic [3:0] aluOp;
	logic [1:0] memSize, wbSel;
	logic [4:0] dest;
	logic useImm, zeroExt, regWe, memRd, memWr, usesRs, usesRt, isJr, isCond, rsEqRt;

	regFile u_regFile (.clk(clk), .rst(rst), .raddrA(idInstr.r.rs), .raddrB(idInstr.r.rt),
		.we(wbWe), .waddr(wbDest), .wdata(wbData), .rdataA(rdataA), .rdataB(rdataB));

	assign op = idInstr.r.op;

	always_comb begin
		aluOp = pipePkg::aluAdd;
		useImm = 1'b1;
		zeroExt = 1'b0;
		dest = idInstr.i.rt;
		regWe = 1'b0;
		memRd = 1'b0;
		memWr = 1'b0;
		memSize = pipePkg::memWord;
		wbSel = pipePkg::wbAlu;
		usesRs = 1'b1;
		usesRt = 1'b0;
		isJr = 1'b0;
		case (op)
			isaPkg::opSpecial: begin
				useImm = 1'b0;
				dest = idInstr.r.rd;
				usesRt = 1'b1;
				regWe = 1'b1;
				case (idInstr.r.funct)
					isaPkg::fnAddu: aluOp = pipePkg::aluAdd;
					isaPkg::fnSubu: aluOp = pipePkg::aluSub;
					isaPkg::fnAnd: aluOp = pipePkg::aluAnd;
					isaPkg::fnOr: aluOp = pipePkg::aluOr;
					isaPkg::fnXor: aluOp = pipePkg::aluXor;
					isaPkg::fnNor: aluOp = pipePkg::aluNor;
					isaPkg::fnSlt: aluOp = pipePkg::aluSlt;
					isaPkg::fnSltu: aluOp = pipePkg::aluSltu;
					isaPkg::fnSll: aluOp = pipePkg::aluSll;
					isaPkg::fnSrl: aluOp = pipePkg::aluSrl;
					isaPkg::fnSra: aluOp = pipePkg::aluSra;
					isaPkg::fnJr: begin
						regWe = 1'b0;
						isJr = 1'b1;
					end
					default: regWe = 1'b0;
				endcase
			end
			isaPkg::opAddiu: regWe = 1'b1;
			isaPkg::opSlti: begin
				regWe = 1'b1;
				aluOp = pipePkg::aluSlt;
			end
			isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori: begin
				regWe = 1'b1;
				zeroExt = 1'b1;
				aluOp = (op == isaPkg::opAndi) ? pipePkg::aluAnd :
					(op == isaPkg::opOri) ? pipePkg::aluOr : pipePkg::aluXor;
			end
			isaPkg::opLui: begin
				regWe = 1'b1;
				aluOp = pipePkg::aluLui;
			end
			isaPkg::opLb, isaPkg::opLbu, isaPkg::opLw: begin
				regWe = 1'b1;
				memRd = 1'b1;
				wbSel = pipePkg::wbMem;
				memSize = (op == isaPkg::opLw) ? pipePkg::memWord :
					(op == isaPkg::opLb) ? pipePkg::memByte : pipePkg::memByteU;
			end
			isaPkg::opSb, isaPkg::opSw: begin
				memWr = 1'b1;
				usesRt = 1'b1;
				memSize = (op == isaPkg::opSw) ? pipePkg::memWord : pipePkg::memByte;
			end
			isaPkg::opBeq, isaPkg::opBne: usesRt = 1'b1;
			isaPkg::opJ: usesRs = 1'b0; // Fetch handles the jump itself.
			isaPkg::opJal: begin
				usesRs = 1'b0;
				regWe = 1'b1;
				dest = 5'd31;
				wbSel = pipePkg::wbLink;
			end
			default: usesRs = 1'b0; // Reserved, runs as a nop.
		endcase
	end

	// Shifts carry shamt in the immediate slot.
	assign immExt = (op == isaPkg::opSpecial) ? {27'd0, idInstr.r.shamt} :
		zeroExt ? {16'd0, idInstr.i.imm} : {{16{idInstr.i.imm[15]}}, idInstr.i.imm};

	assign srcRs = usesRs ? idInstr.r.rs : 5'd0;
	assign srcRt = usesRt ? idInstr.r.rt : 5'd0;
	assign isCond = (op == isaPkg::opBeq) || (op == isaPkg::opBne);
	assign idIsBranch = isCond || isJr;

	assign rsVal = (fwdA == pipePkg::fwdMem) ? memResult : rdataA;
	assign rtVal = (fwdB == pipePkg::fwdMem) ? memResult : rdataB;
	assign rsEqRt = rsVal == rtVal;
	assign branchTaken = isJr || (isCond && (rsEqRt == (op == isaPkg::opBeq)));
	assign branchTarget = isJr ? rsVal :
		idPc + 32'd4 + {{14{idInstr.i.imm[15]}}, idInstr.i.imm, 2'b00};

	always_ff @(posedge clk) begin
		exPc <= idPc;
		exA <= rdataA;
		exB <= rdataB;
		exImm <= immExt;
		exAluOp <= aluOp;
		exUseImm <= useImm;
		exDest <= dest;
		exMemSize <= memSize;
		exWbSel <= wbSel;
		exRs <= srcRs;
		exRt <= srcRt;
		if (rst || stall) begin
			exRegWe <= 1'b0; // Bubble.
			exMemRd <= 1'b0;
			exMemWr <= 1'b0;
		end else begin
			exRegWe <= regWe;
			exMemRd <= memRd;
			exMemWr <= memWr;
		end
	end

endmodule

//--- source/fetchStage.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetchStage (
	input logic clk, rst, stall, branchTaken,
	input logic [`DATA_W-1:0] branchTarget,
	input logic [`DATA_W-1:0] instSramRdata,
	output logic instSramEn,
	output logic [`DATA_W-1:0] instSramAddr,
	output logic [`DATA_W-1:0] idPc,
	output isaPkg::instrWord idInstr
);
	logic [`DATA_W-1:0] pc; // Address of the word now returning.
	logic [`DATA_W-1:0] nextPc;
	logic [`DATA_W-1:0] jumpTarget;
	logic started;
	logic isJump;

	assign isJump = (idInstr.j.op == isaPkg::opJ) || (idInstr.j.op == isaPkg::opJal);
	assign jumpTarget = {pc[31:28], idInstr.j.target, 2'b00}; // pc is the delay slot here.

	always_comb begin
		if (!started)
			nextPc = `RESET_PC;
		else if (stall)
			nextPc = pc; // Refetch the held word.
		else if (isJump)
			nextPc = jumpTarget;
		else if (branchTaken)
			nextPc = branchTarget;
		else
			nextPc = pc + 32'd4;
	end

	assign instSramEn = ~rst;
	assign instSramAddr = nextPc;

	always_ff @(posedge clk) begin
		if (rst) begin
			started <= 1'b0;
			pc <= `RESET_PC;
			idPc <= '0;
			idInstr <= '0;
		end else begin
			started <= 1'b1;
			pc <= nextPc;
			if (!stall) begin
				idPc <= pc;
				idInstr <= started ? instSramRdata : '0; // Nop until the first word.
			end
		end
	end

	aAligned: assert property (@(posedge clk) disable iff (rst)
		instSramEn |-> instSramAddr[1:0] == 2'b00);

endmodule

//--- source/executeStage.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module executeStage (
	input logic clk, rst,
	input logic [`DATA_W-1:0] exPc, exA, exB, exImm,
	input logic [3:0] exAluOp,
	input logic exUseImm, exRegWe, exMemRd, exMemWr,
	input logic [4:0] exDest,
	input logic [1:0] exMemSize, exWbSel,
	input logic [1:0] fwdA, fwdB,
	input logic [`DATA_W-1:0] wbData,
	output logic [`DATA_W-1:0] memResult,
	output logic dataSramEn,
	output logic [3:0] dataSramWen,
	output logic [`DATA_W-1:0] dataSramAddr, dataSramWdata,
	output logic [`DATA_W-1:0] memPc, memValue,
	output logic [4:0] memDest,
	output logic memRegWe, memRd,
	output logic [1:0] memSize, memByteLane, memWbSel
);
	logic [`DATA_W-1:0] opA, opB, aluB, aluResult;
	logic [3:0] byteMask;

	function automatic logic [`DATA_W-1:0] pickOperand(input logic [1:0] sel,
			input logic [`DATA_W-1:0] regVal, memVal, wbVal);
		case (sel)
			pipePkg::fwdMem: return memVal;
			pipePkg::fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign opA = pickOperand(fwdA, exA, memResult, wbData);
	assign opB = pickOperand(fwdB, exB, memResult, wbData);
	assign aluB = exUseImm ? exImm : opB;

	always_comb begin
		case (exAluOp)
			pipePkg::aluSub: aluResult = opA - aluB;
			pipePkg::aluAnd: aluResult = opA & aluB;
			pipePkg::aluOr: aluResult = opA | aluB;
			pipePkg::aluXor: aluResult = opA ^ aluB;
			pipePkg::aluNor: aluResult = ~(opA | aluB);
			pipePkg::aluSlt: aluResult = `DATA_W'($signed(opA) < $signed(aluB));
			pipePkg::aluSltu: aluResult = `DATA_W'(opA < aluB);
			pipePkg::aluSll: aluResult = opB << exImm[4:0];
			pipePkg::aluSrl: aluResult = opB >> exImm[4:0];
			pipePkg::aluSra: aluResult = $signed(opB) >>> exImm[4:0];
			pipePkg::aluLui: aluResult = {aluB[15:0], 16'd0};
			default: aluResult = opA + aluB;
		endcase
	end

	assign byteMask = (exMemSize == pipePkg::memWord) ? 4'hf : 4'b0001 << aluResult[1:0];
	assign dataSramEn = exMemRd | exMemWr;
	assign dataSramWen = exMemWr ? byteMask : 4'h0;
	assign dataSramAddr = aluResult;
	assign dataSramWdata = (exMemSize == pipePkg::memWord) ? opB : {4{opB[7:0]}};

	// Link value must be visible to a jr right behind the jal.
	assign memResult = (memWbSel == pipePkg::wbLink) ? memPc + 32'd8 : memValue;

	always_ff @(posedge clk) begin
		memPc <= exPc;
		memValue <= aluResult;
		memDest <= exDest;
		memSize <= exMemSize;
		memByteLane <= aluResult[1:0];
		memWbSel <= exWbSel;
		if (rst) begin
			memRegWe <= 1'b0;
			memRd <= 1'b0;
		end else begin
			memRegWe <= exRegWe;
			memRd <= exMemRd;
		end
	end

	aWenEn: assert property (@(posedge clk) disable iff (rst)
		dataSramWen != 4'h0 |-> dataSramEn && !exMemRd);

endmodule

//--- source/memoryStage.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module memoryStage (
	input logic clk, rst,
	input logic [`DATA_W-1:0] memPc, memValue, dataSramRdata,
	input logic [4:0] memDest,
	input logic memRegWe, memRd,
	input logic [1:0] memSize, memByteLane, memWbSel,
	output logic wbWe,
	output logic [4:0] wbDest,
	output logic [`DATA_W-1:0] wbData, debugWbPc, debugWbRfWdata,
	output logic [3:0] debugWbRfWen,
	output logic [4:0] debugWbRfWnum
);
	logic [7:0] loadByte;
	logic [`DATA_W-1:0] loadData, wbPc, wbValue, wbLoad;
	logic [1:0] wbSel;

	assign loadByte = dataSramRdata[{memByteLane, 3'b000} +: 8];

	always_comb begin
		case (memSize)
			pipePkg::memByte: loadData = {{24{loadByte[7]}}, loadByte};
			pipePkg::memByteU: loadData = {24'd0, loadByte};
			default: loadData = dataSramRdata;
		endcase
	end

	always_ff @(posedge clk) begin
		wbPc <= memPc;
		wbDest <= memDest;
		wbSel <= memWbSel;
		wbValue <= memValue;
		if (memRd)
			wbLoad <= loadData;
		if (rst)
			wbWe <= 1'b0;
		else
			wbWe <= memRegWe && memDest != 5'd0; // r0 writes never reach the trace.
	end

	assign wbData = (wbSel == pipePkg::wbMem) ? wbLoad :
		(wbSel == pipePkg::wbLink) ? wbPc + 32'd8 : wbValue;

	assign debugWbPc = wbPc;
	assign debugWbRfWen = {4{wbWe}};
	assign debugWbRfWnum = wbDest;
	assign debugWbRfWdata = wbData;

endmodule

//--- source/hazardUnit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module hazardUnit #(localparam int addrW = $clog2(`REG_COUNT)) (
	input logic clk, rst,
	input logic [addrW-1:0] srcRs, srcRt, exRs, exRt, exDest, memDest, wbDest,
	input logic idIsBranch, exRegWe, exMemRd, memRegWe, memRd, wbWe,
	output logic stall,
	output logic [1:0] fwdA, fwdB, brFwdA, brFwdB
);
	logic loadUse, branchWait, memFwdOk;

	function automatic logic hit(input logic [addrW-1:0] dest, src);
		return dest != '0 && dest == src;
	endfunction

	assign loadUse = exMemRd && (hit(exDest, srcRs) || hit(exDest, srcRt));
	// Compare needs the value in decode, so EX results and MEM loads wait.
	assign branchWait = idIsBranch &&
		((exRegWe && (hit(exDest, srcRs) || hit(exDest, srcRt))) ||
		(memRegWe && memRd && (hit(memDest, srcRs) || hit(memDest, srcRt))));
	assign stall = loadUse || branchWait;

	assign memFwdOk = memRegWe && !memRd; // Load data is not ready in MEM.
	assign fwdA = (memFwdOk && hit(memDest, exRs)) ? pipePkg::fwdMem :
		(wbWe && hit(wbDest, exRs)) ? pipePkg::fwdWb : pipePkg::fwdReg;
	assign fwdB = (memFwdOk && hit(memDest, exRt)) ? pipePkg::fwdMem :
		(wbWe && hit(wbDest, exRt)) ? pipePkg::fwdWb : pipePkg::fwdReg;
	assign brFwdA = (memFwdOk && hit(memDest, srcRs)) ? pipePkg::fwdMem : pipePkg::fwdReg;
	assign brFwdB = (memFwdOk && hit(memDest, srcRt)) ? pipePkg::fwdMem : pipePkg::fwdReg;

	// The bubble behind a stall clears the load from execute.
	aLoadUseOnce: assert property (@(posedge clk) disable iff (rst) loadUse |=> !loadUse);

endmodule

//--- source/mipsCore.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module mipsCore (
	input logic clk, rst,
	output logic instSramEn,
	output logic [`DATA_W-1:0] instSramAddr,
	input logic [`DATA_W-1:0] instSramRdata,
	output logic dataSramEn,
	output logic [3:0] dataSramWen,
	output logic [`DATA_W-1:0] dataSramAddr, dataSramWdata,
	input logic [`DATA_W-1:0] dataSramRdata,
	output logic [`DATA_W-1:0] debugWbPc,
	output logic [3:0] debugWbRfWen,
	output logic [4:0] debugWbRfWnum,
	output logic [`DATA_W-1:0] debugWbRfWdata
);
	logic stall, branchTaken, idIsBranch;
	logic [`DATA_W-1:0] branchTarget, idPc;
	isaPkg::instrWord idInstr;
	logic [4:0] srcRs, srcRt;

	logic [`DATA_W-1:0] exPc, exA, exB, exImm;
	logic [3:0] exAluOp;
	logic exUseImm, exRegWe, exMemRd, exMemWr;
	logic [4:0] exDest, exRs, exRt;
	logic [1:0] exMemSize, exWbSel;
	logic [1:0] fwdA, fwdB, brFwdA, brFwdB;

	logic [`DATA_W-1:0] memResult, memPc, memValue;
	logic [4:0] memDest;
	logic memRegWe, memRd;
	logic [1:0] memSize, memByteLane, memWbSel;

	logic wbWe;
	logic [4:0] wbDest;
	logic [`DATA_W-1:0] wbData;

	fetchStage u_fetchStage (.*);
	decodeStage u_decodeStage (.*, .fwdA(brFwdA), .fwdB(brFwdB)); // Branch compare selects.
	executeStage u_executeStage (.*);
	memoryStage u_memoryStage (.*);
	hazardUnit u_hazardUnit (.*);

endmodule

//--- tests/mipsCore_tb.sv
`timescale 1ns/1ps

module mipsCore_tb;
	logic clk, rst;
	logic instSramEn;
	logic [31:0] instSramAddr, instSramRdata;
	logic dataSramEn;
	logic [3:0] dataSramWen;
	logic [31:0] dataSramAddr, dataSramWdata, dataSramRdata;
	logic [31:0] debugWbPc, debugWbRfWdata;
	logic [3:0] debugWbRfWen;
	logic [4:0] debugWbRfWnum;

	logic [31:0] imem [64];
	logic [7:0] dmem [256];
	logic [31:0] base, iAddrQ;
	logic [7:0] dAddrQ;
	logic [31:0] expPc [$], expReg [$], expData [$];
	logic [31:0] expAddr [$], expMask [$], expWdata [$];
	int progWords, checks, errors, cycles, limit;
	int groupErr [3]; // Reset, trace, stores.
	bit checking, timedOut;

	mipsCore u_mipsCore (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) cycles <= cycles + 1;

	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		logic [31:0] idx;
		idx = (addr - base) >> 2;
		return (idx < 64) ? imem[idx] : 32'h0;
	endfunction

	task automatic checkValue(input int group, input string name, input logic [31:0] got, exp);
		checks++;
		if (got !== exp) begin
			errors++;
			groupErr[group]++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic loadStimulus();
		string line;
		int fd;
		logic [31:0] a, b, c;
		fd = $fopen("tests/mipsCore_stimulus.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the stimulus file");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1) begin
					case (line[0])
						"B": void'($sscanf(line, "B %h", base));
						"I": begin
							void'($sscanf(line, "I %h", a));
							imem[progWords] = a;
							progWords++;
						end
						"T": begin
							void'($sscanf(line, "T %h %h %h", a, b, c));
							expPc.push_back(a);
							expReg.push_back(b);
							expData.push_back(c);
						end
						"S": begin
							void'($sscanf(line, "S %h %h %h", a, b, c));
							expAddr.push_back(a);
							expMask.push_back(b);
							expWdata.push_back(c);
						end
						default: ; // Comment line.
					endcase
				end
			end
			$fclose(fd);
		end
	endtask

	// SRAM models, one cycle read latency.
	always @(negedge clk) begin
		instSramRdata = fetchWord(iAddrQ);
		iAddrQ = instSramAddr;
		dataSramRdata = {dmem[dAddrQ + 3], dmem[dAddrQ + 2], dmem[dAddrQ + 1], dmem[dAddrQ]};
		if (dataSramEn) begin
			dAddrQ = {dataSramAddr[7:2], 2'b00};
			for (int k = 0; k < 4; k++)
				if (dataSramWen[k])
					dmem[{dataSramAddr[7:2], 2'(k)}] = dataSramWdata[8 * k +: 8];
		end
	end

	// Trace and store checkers.
	always @(negedge clk) begin
		if (checking && debugWbRfWen != 4'h0) begin
			if (expPc.size() == 0) begin
				errors++;
				groupErr[1]++;
				$display("unexpected register write at pc %h", debugWbPc);
			end else begin
				checkValue(1, "debugWbRfWen", 32'(debugWbRfWen), 32'hf);
				checkValue(1, "debugWbPc", debugWbPc, expPc.pop_front());
				checkValue(1, "debugWbRfWnum", 32'(debugWbRfWnum), expReg.pop_front());
				checkValue(1, "debugWbRfWdata", debugWbRfWdata, expData.pop_front());
			end
		end
		if (checking && dataSramEn && dataSramWen != 4'h0) begin
			if (expAddr.size() == 0) begin
				errors++;
				groupErr[2]++;
				$display("unexpected store to address %h", dataSramAddr);
			end else begin
				checkValue(2, "dataSramAddr", dataSramAddr, expAddr.pop_front());
				checkValue(2, "dataSramWen", 32'(dataSramWen), expMask.pop_front());
				checkValue(2, "dataSramWdata", dataSramWdata, expWdata.pop_front());
			end
		end
	end

	initial begin
		rst = 1'b1;
		instSramRdata = '0;
		dataSramRdata = '0;
		iAddrQ = '0;
		dAddrQ = '0;
		base = '0;
		cycles = 0;
		foreach (imem[i]) imem[i] = '0;
		foreach (dmem[i]) dmem[i] = 8'(i) ^ 8'ha5;
		loadStimulus();
		limit = progWords * 20 + 100;

		repeat (16) begin
			@(negedge clk);
			checkValue(0, "instSramEn", 32'(instSramEn), 0);
			checkValue(0, "dataSramEn", 32'(dataSramEn), 0);
			checkValue(0, "dataSramWen", 32'(dataSramWen), 0);
			checkValue(0, "debugWbRfWen", 32'(debugWbRfWen), 0);
		end
		rst = 1'b0;
		#1;
		checkValue(0, "instSramEn", 32'(instSramEn), 1);
		checkValue(0, "instSramAddr", instSramAddr, base);
		checkValue(0, "dataSramEn", 32'(dataSramEn), 0);
		checkValue(0, "debugWbRfWen", 32'(debugWbRfWen), 0);
		$display("reset: %0d errors", groupErr[0]);
		checking = 1'b1;

		while ((expPc.size() > 0 || expAddr.size() > 0) && cycles < limit)
			@(negedge clk);
		if (cycles >= limit) begin
			timedOut = 1'b1;
			$display("timeout: the program did not finish within %0d cycles", limit);
		end else begin
			repeat (10) @(negedge clk); // Catch stray writes.
		end
		$display("trace: %0d errors, %0d entries left", groupErr[1], expPc.size());
		$display("stores: %0d errors, %0d entries left", groupErr[2], expAddr.size());
		$display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
		if (errors == 0 && !timedOut) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- mipsCore.f
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
decode/regFile.sv
decode/decodeStage.sv
source/fetchStage.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardUnit.sv
source/mipsCore.sv
tests/mipsCore_tb.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f mipsCore.f --top-module mipsCore

sim:
	verilator --binary --timing --assert -f mipsCore.f --top-module mipsCore_tb -o simv
	@out=$$(./obj_dir/simv); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- tests/mipsCore_stimulus.txt
# B base address, I program word in order from base
# T pc reg data written back, S store addr mask data
B bfc00000
I 3c011234
I 34215678
I 00211021
I 00411823
I ac030000
I 2404ff80
I a0040005
I 80050005
I 24a60001
I 90070001
I 0080402a
I 0080482b
I 15200002
I 00000000
I 11080002
I 390a00ff
I 300a0000
I 0ff00016
I 000a5900
I 00047103
I 0bf00014
I 00000000
I 00046702
I 03e00008
I 00806827
T bfc00000 01 12340000
T bfc00004 01 12345678
T bfc00008 02 2468acf0
T bfc0000c 03 12345678
T bfc00014 04 ffffff80
T bfc0001c 05 ffffff80
T bfc00020 06 ffffff81
T bfc00024 07 00000056
T bfc00028 08 00000001
T bfc0002c 09 00000000
T bfc0003c 0a 000000fe
T bfc00044 1f bfc0004c
T bfc00048 0b 00000fe0
T bfc00058 0c 0000000f
T bfc00060 0d 0000007f
T bfc0004c 0e fffffff8
S 00000000 f 12345678
S 00000005 2 80808080
